//--- sysctl_pkg.sv
`default_nettype none

// Peripheral bus widths and the bus request and response structs
package sysctl_pkg;

	// Data width of the bus
	localparam int ARCHBITSZ = 32;

	// Word address width; byte address is {addr, 2'b00}
	localparam int ADDRBITSZ = 30;

	// Byte select width
	localparam int SELBITSZ = ARCHBITSZ / 8;

	// Request driven by a master
	typedef struct packed {
		logic                   cyc;
		logic                   stb;
		logic                   we;
		logic [ADDRBITSZ-1:0]   addr;
		logic [SELBITSZ-1:0]    sel;
		logic [ARCHBITSZ-1:0]   dat;
	} pi_req_t;

	// Response returned by a slave
	typedef struct packed {
		logic                   bsy;
		logic                   ack;
		logic [ARCHBITSZ-1:0]   dat;
	} pi_rsp_t;

endpackage

`default_nettype wire

//--- devmap_pkg.sv
`default_nettype none

// Fixed device map of the peripheral bus
package devmap_pkg;

	// Slave indices in address order
	typedef enum logic [2:0] {
		SLV_SDCARD  = 3'd0,
		SLV_DEVTBL  = 3'd1,
		SLV_IRQCTRL = 3'd2,
		SLV_SERIAL  = 3'd3,
		SLV_RAM     = 3'd4,
		SLV_RAMCTRL = 3'd5,
		SLV_BOOTLDR = 3'd6,
		SLV_INVALID = 3'd7
	} slave_e;

	localparam int SLAVECOUNT = 8;

	// All slaves but the device table and the invalid device
	localparam int EXTCOUNT = 6;

	// Window sizes in bytes, laid end to end from address 0
	localparam logic [31:0] DEV_MAPSZ [SLAVECOUNT] = '{
		32'h0000_1000,
		32'h0000_1000,
		32'h0000_1000,
		32'h0000_1000,
		32'h2000_0000,
		32'h0001_0000,
		32'h0000_1000,
		32'h0000_1000
	};

	// Device identifiers reported by the device table
	localparam logic [31:0] DEV_ID [SLAVECOUNT] = '{
		32'd4, 32'd7, 32'd3, 32'd5, 32'd1, 32'd0, 32'd0, 32'd0
	};

	// Interrupt use, one bit per slave; sdcard and serial only
	localparam logic [SLAVECOUNT-1:0] DEV_USEIRQ = 8'b0000_1001;

	// Word index of the reset control register
	localparam int RSTCTRL_IDX = 16;

endpackage

`default_nettype wire

//--- rst_seq.sv
`default_nettype none

module rst_seq #(
	parameter int RST_CNTR_BITSZ = 16
) (
	input  wire       clk_4x_w,
	input  wire       devtbl_rst2_w,
	input  wire       usr_btn_n_i,
	input  wire       pll_locked_i,
	input  wire       cpu_rst_i,
	input  wire [1:0] rst_ctrl_i,
	output logic      sys_rst_o
);

	// Codes written by software to the reset control register
	typedef enum logic [1:0] {
		RC_IDLE   = 2'b00,
		RC_PWROFF = 2'b01,
		RC_WARM   = 2'b10
	} rst_code_e;

	logic [RST_CNTR_BITSZ-1:0] rst_cntr;
	logic                      pwroff_r;
	logic                      btn_p;
	logic                      swwarmrst;
	logic                      swpwroff;

	assign btn_p     = !usr_btn_n_i;
	assign swwarmrst = (rst_ctrl_i == RC_WARM);
	assign swpwroff  = (rst_ctrl_i == RC_PWROFF);

	// Counter reloads on any reset source, then runs down to zero
	always_ff @(posedge clk_4x_w) begin
		if (devtbl_rst2_w || btn_p || cpu_rst_i || swwarmrst) begin
			rst_cntr <= '1;
		end else if (rst_cntr != '0) begin
			rst_cntr <= rst_cntr - 1'b1;
		end
	end

	// Power-off latch, only the button brings the system back
	always_ff @(posedge clk_4x_w) begin
		if (devtbl_rst2_w) begin
			pwroff_r <= 1'b0;
		end else if (swpwroff) begin
			pwroff_r <= 1'b1;
		end else if (btn_p) begin
			pwroff_r <= 1'b0;
		end
	end

	assign sys_rst_o = !pll_locked_i || pwroff_r || (rst_cntr != '0);

endmodule

`default_nettype wire

//--- pi_decoder.sv
`default_nettype none

module pi_decoder (
	input  wire sysctl_pkg::pi_req_t m_req_i,
	output sysctl_pkg::pi_rsp_t      m_rsp_o,
	output sysctl_pkg::pi_req_t      s_req_o,
	output logic [devmap_pkg::EXTCOUNT-1:0] s_cyc_o,
	output logic [devmap_pkg::EXTCOUNT-1:0] s_stb_o,
	input  wire sysctl_pkg::pi_rsp_t s_rsp_i [devmap_pkg::EXTCOUNT],
	output sysctl_pkg::pi_req_t      dt_req_o,
	input  wire sysctl_pkg::pi_rsp_t dt_rsp_i
);

	localparam int EXTIDXBITSZ = $clog2(devmap_pkg::EXTCOUNT);

	// End address (exclusive) of window idx
	function automatic logic [sysctl_pkg::ARCHBITSZ:0] win_end(input int idx);
		logic [sysctl_pkg::ARCHBITSZ:0] acc;
		acc = '0;
		for (int i = 0; i <= idx; i++) begin
			acc = acc + {1'b0, devmap_pkg::DEV_MAPSZ[i]};
		end
		return acc;
	endfunction

	// External port number of a slave; the device table takes no port
	function automatic logic [EXTIDXBITSZ-1:0] ext_of(input devmap_pkg::slave_e s);
		logic [EXTIDXBITSZ-1:0] k;
		if (s < devmap_pkg::SLV_DEVTBL) begin
			k = EXTIDXBITSZ'(s);
		end else begin
			k = EXTIDXBITSZ'(s - 1);
		end
		return k;
	endfunction

	logic [sysctl_pkg::ARCHBITSZ:0] byte_addr;
	devmap_pkg::slave_e             sel;
	logic [EXTIDXBITSZ-1:0]         ext_idx;

	assign byte_addr = {1'b0, m_req_i.addr, 2'b00};

	// Windows are consecutive, so the first one whose end lies above the address wins
	always_comb begin
		sel = devmap_pkg::SLV_INVALID;
		for (int i = int'(devmap_pkg::SLV_INVALID) - 1; i >= 0; i--) begin
			if (byte_addr < win_end(i)) begin
				sel = devmap_pkg::slave_e'(i);
			end
		end
	end

	assign ext_idx = ext_of(sel);

	always_comb begin
		// Strobes travel only on the per-slave lines
		s_req_o     = m_req_i;
		s_req_o.cyc = 1'b0;
		s_req_o.stb = 1'b0;
		dt_req_o     = m_req_i;
		dt_req_o.cyc = 1'b0;
		dt_req_o.stb = 1'b0;
		s_cyc_o = '0;
		s_stb_o = '0;
		// Invalid device: never busy, never acks
		m_rsp_o = '0;
		case (sel)
			devmap_pkg::SLV_DEVTBL: begin
				dt_req_o.cyc = m_req_i.cyc;
				dt_req_o.stb = m_req_i.stb;
				m_rsp_o      = dt_rsp_i;
			end
			devmap_pkg::SLV_INVALID: begin
				m_rsp_o = '0;
			end
			default: begin
				s_cyc_o[ext_idx] = m_req_i.cyc;
				s_stb_o[ext_idx] = m_req_i.stb;
				m_rsp_o          = s_rsp_i[ext_idx];
			end
		endcase
	end

endmodule

`default_nettype wire

//--- devtbl_regs.sv
`default_nettype none

module devtbl_regs (
	input  wire                      clk_4x_w,
	input  wire                      devtbl_rst2_w,
	input  wire                      sys_rst_i,
	input  wire sysctl_pkg::pi_req_t req_i,
	output sysctl_pkg::pi_rsp_t      rsp_o,
	output logic [1:0]               rst_ctrl_o
);

	// Word offset bits inside the device table window
	localparam int IDXBITSZ = $clog2(devmap_pkg::DEV_MAPSZ[devmap_pkg::SLV_DEVTBL]) - 2;
	localparam int DEVBITSZ = $clog2(devmap_pkg::SLAVECOUNT);

	logic                           rst;
	logic                           req;
	logic [IDXBITSZ-1:0]            word_idx;
	logic [DEVBITSZ-1:0]            dev_k;
	logic [sysctl_pkg::ARCHBITSZ-1:0] rd_data;
	logic [sysctl_pkg::ARCHBITSZ-1:0] rdat_r;
	logic                           ack_r;
	logic [1:0]                     rst_ctrl_r;

	assign rst      = devtbl_rst2_w || sys_rst_i;
	assign req      = req_i.cyc && req_i.stb;
	assign word_idx = req_i.addr[IDXBITSZ-1:0];
	assign dev_k    = word_idx[DEVBITSZ:1];

	// Even words give id and useirq, odd words give the map size
	always_comb begin
		rd_data = '0;
		if (word_idx < IDXBITSZ'(2 * devmap_pkg::SLAVECOUNT)) begin
			if (word_idx[0]) begin
				rd_data = devmap_pkg::DEV_MAPSZ[dev_k];
			end else begin
				rd_data     = devmap_pkg::DEV_ID[dev_k];
				rd_data[31] = devmap_pkg::DEV_USEIRQ[dev_k];
			end
		end else if (word_idx == IDXBITSZ'(devmap_pkg::RSTCTRL_IDX)) begin
			rd_data[1:0] = rst_ctrl_r;
		end
	end

	always_ff @(posedge clk_4x_w) begin
		if (rst) begin
			ack_r      <= 1'b0;
			rst_ctrl_r <= 2'b00;
		end else begin
			ack_r <= req;
			if (req && req_i.we && req_i.sel[0] &&
					word_idx == IDXBITSZ'(devmap_pkg::RSTCTRL_IDX)) begin
				rst_ctrl_r <= req_i.dat[1:0];
			end
		end
	end

	// Read data is captured with the request
	always_ff @(posedge clk_4x_w) begin
		if (req) begin
			rdat_r <= rd_data;
		end
	end

	assign rsp_o.bsy  = 1'b0;
	assign rsp_o.ack  = ack_r;
	assign rsp_o.dat  = rdat_r;
	assign rst_ctrl_o = rst_ctrl_r;

endmodule

`default_nettype wire

//--- soc_sysctl_top.sv
`default_nettype none

module soc_sysctl_top #(
	parameter int RST_CNTR_BITSZ = 4
) (
	input  wire                      clk_4x_w,
	input  wire                      devtbl_rst2_w,
	input  wire                      usr_btn_n_i,
	input  wire                      pll_locked_i,
	input  wire                      cpu_rst_i,
	input  wire sysctl_pkg::pi_req_t m_req_i,
	output wire sysctl_pkg::pi_rsp_t m_rsp_o,
	output wire sysctl_pkg::pi_req_t s_req_o,
	output wire [devmap_pkg::EXTCOUNT-1:0] s_cyc_o,
	output wire [devmap_pkg::EXTCOUNT-1:0] s_stb_o,
	input  wire sysctl_pkg::pi_rsp_t s_rsp_i [devmap_pkg::EXTCOUNT],
	output wire                      sys_rst_o
);

	wire sysctl_pkg::pi_req_t dt_req_w;
	wire sysctl_pkg::pi_rsp_t dt_rsp_w;
	wire [1:0]                rst_ctrl_w;

	rst_seq #(
		.RST_CNTR_BITSZ (RST_CNTR_BITSZ)
	) u_rst_seq (
		.clk_4x_w      (clk_4x_w),
		.devtbl_rst2_w (devtbl_rst2_w),
		.usr_btn_n_i   (usr_btn_n_i),
		.pll_locked_i  (pll_locked_i),
		.cpu_rst_i     (cpu_rst_i),
		.rst_ctrl_i    (rst_ctrl_w),
		.sys_rst_o     (sys_rst_o)
	);

	// Combinational, so accesses take the slave's own latency
	pi_decoder u_pi_decoder (
		.m_req_i  (m_req_i),
		.m_rsp_o  (m_rsp_o),
		.s_req_o  (s_req_o),
		.s_cyc_o  (s_cyc_o),
		.s_stb_o  (s_stb_o),
		.s_rsp_i  (s_rsp_i),
		.dt_req_o (dt_req_w),
		.dt_rsp_i (dt_rsp_w)
	);

	devtbl_regs u_devtbl_regs (
		.clk_4x_w      (clk_4x_w),
		.devtbl_rst2_w (devtbl_rst2_w),
		.sys_rst_i     (sys_rst_o),
		.req_i         (dt_req_w),
		.rsp_o         (dt_rsp_w),
		.rst_ctrl_o    (rst_ctrl_w)
	);

endmodule

`default_nettype wire

//--- tb_checker.sv
`default_nettype none

module tb_checker (
	input  wire                      clk_4x_w,
	input  wire sysctl_pkg::pi_req_t m_req_i,
	input  wire sysctl_pkg::pi_rsp_t m_rsp_i,
	input  wire sysctl_pkg::pi_req_t s_req_i,
	input  wire [devmap_pkg::EXTCOUNT-1:0] s_cyc_i,
	input  wire [devmap_pkg::EXTCOUNT-1:0] s_stb_i,
	input  wire                      sys_rst_i,
	input  wire [31:0]               exp_dat_i,
	input  wire [devmap_pkg::EXTCOUNT-1:0] exp_stb_i,
	input  wire                      chk_dat_i,
	input  wire                      noack_i,
	input  wire                      mark_i,
	input  wire                      hold_i,
	input  wire [31:0]               exp_rel_i,
	output int                       err_cnt_o
);

	logic in_xfer;
	logic prev_req;
	logic armed;
	int   lat;
	int   cnt;

	initial begin
		err_cnt_o = 0;
		in_xfer   = 1'b0;
		prev_req  = 1'b0;
		armed     = 1'b0;
		lat       = 0;
		cnt       = 0;
	end

	// Samples on the rising edge, before the DUT registers update
	always @(posedge clk_4x_w) begin
		if (in_xfer) begin
			lat++;
			if (m_rsp_i.ack) begin
				in_xfer = 1'b0;
				if (lat != 1) begin
					$display("Error at %0t: m_rsp_o.ack latency got %0d expected 1",
						$time, lat);
					err_cnt_o++;
				end
				if (chk_dat_i && m_rsp_i.dat !== exp_dat_i) begin
					$display("Error at %0t: m_rsp_o.dat got %h expected %h",
						$time, m_rsp_i.dat, exp_dat_i);
					err_cnt_o++;
				end
			end
		end
		if (m_req_i.cyc && m_req_i.stb) begin
			if (s_stb_i !== exp_stb_i) begin
				$display("Error at %0t: s_stb_o got %b expected %b", $time, s_stb_i, exp_stb_i);
				err_cnt_o++;
			end
			if (s_cyc_i !== exp_stb_i) begin
				$display("Error at %0t: s_cyc_o got %b expected %b", $time, s_cyc_i, exp_stb_i);
				err_cnt_o++;
			end
			if (m_rsp_i.bsy !== 1'b0) begin
				$display("Error at %0t: m_rsp_o.bsy got %b expected 0", $time, m_rsp_i.bsy);
				err_cnt_o++;
			end
			// The shared slave request carries the master's fields
			if (exp_stb_i != '0 &&
					{s_req_i.we, s_req_i.addr, s_req_i.sel, s_req_i.dat} !==
					{m_req_i.we, m_req_i.addr, m_req_i.sel, m_req_i.dat}) begin
				$display("Error at %0t: s_req_o got %h expected %h", $time,
					{s_req_i.we, s_req_i.addr, s_req_i.sel, s_req_i.dat},
					{m_req_i.we, m_req_i.addr, m_req_i.sel, m_req_i.dat});
				err_cnt_o++;
			end
			if (noack_i && m_rsp_i.ack) begin
				$display("Access to an unmapped address was acknowledged at %0t", $time);
				err_cnt_o++;
			end
			if (!in_xfer && !prev_req && !noack_i) begin
				if (m_rsp_i.ack) begin
					$display("Error at %0t: m_rsp_o.ack latency got 0 expected 1", $time);
					err_cnt_o++;
				end else begin
					in_xfer = 1'b1;
					lat = 0;
				end
			end
		end
		prev_req = m_req_i.cyc && m_req_i.stb;
		if (hold_i && !sys_rst_i) begin
			$display("sys_rst_o dropped during power-off at %0t", $time);
			err_cnt_o++;
		end
		// Cycles from the marked event until sys_rst_o falls
		if (armed) begin
			cnt++;
			if (!sys_rst_i) begin
				armed = 1'b0;
				if (cnt != int'(exp_rel_i)) begin
					$display("Error at %0t: sys_rst_o release cycles got %0d expected %0d",
						$time, cnt, exp_rel_i);
					err_cnt_o++;
				end
			end else if (cnt > int'(exp_rel_i) + 4) begin
				armed = 1'b0;
				$display("sys_rst_o was not released in time at %0t", $time);
				err_cnt_o++;
			end
		end
		if (mark_i && !armed) begin
			armed = 1'b1;
			cnt = 0;
			if (!sys_rst_i) begin
				$display("sys_rst_o was not high after the reset event at %0t", $time);
				err_cnt_o++;
			end
		end
	end

endmodule

`default_nettype wire

//--- tb_soc_sysctl.sv
`default_nettype none

module tb_soc_sysctl;

	localparam int NFIELD = 5;
	localparam int MAXREC = 64;
	localparam int EXT = devmap_pkg::EXTCOUNT;

	logic                clk_4x_w;
	logic                devtbl_rst2_w;
	logic                usr_btn_n_i;
	logic                pll_locked_i;
	logic                cpu_rst_i;
	sysctl_pkg::pi_req_t m_req;
	sysctl_pkg::pi_rsp_t m_rsp;
	sysctl_pkg::pi_req_t s_req;
	logic [EXT-1:0]      s_cyc;
	logic [EXT-1:0]      s_stb;
	sysctl_pkg::pi_rsp_t s_rsp [EXT];
	logic                sys_rst;

	// Expectations handed to the checker
	logic [31:0]         exp_dat;
	logic [EXT-1:0]      exp_stb;
	logic                chk_dat;
	logic                noack;
	logic                mark;
	logic                hold;
	logic [31:0]         exp_rel;
	int                  chk_errs;

	logic [31:0]         stim_mem [0:NFIELD*MAXREC-1];
	logic [EXT-1:0]      pend;
	int                  nrec;
	int                  bus_errs;

	soc_sysctl_top #(
		.RST_CNTR_BITSZ (4)
	) UUT (
		.clk_4x_w      (clk_4x_w),
		.devtbl_rst2_w (devtbl_rst2_w),
		.usr_btn_n_i   (usr_btn_n_i),
		.pll_locked_i  (pll_locked_i),
		.cpu_rst_i     (cpu_rst_i),
		.m_req_i       (m_req),
		.m_rsp_o       (m_rsp),
		.s_req_o       (s_req),
		.s_cyc_o       (s_cyc),
		.s_stb_o       (s_stb),
		.s_rsp_i       (s_rsp),
		.sys_rst_o     (sys_rst)
	);

	tb_checker u_checker (
		.clk_4x_w  (clk_4x_w),
		.m_req_i   (m_req),
		.m_rsp_i   (m_rsp),
		.s_req_i   (s_req),
		.s_cyc_i   (s_cyc),
		.s_stb_i   (s_stb),
		.sys_rst_i (sys_rst),
		.exp_dat_i (exp_dat),
		.exp_stb_i (exp_stb),
		.chk_dat_i (chk_dat),
		.noack_i   (noack),
		.mark_i    (mark),
		.hold_i    (hold),
		.exp_rel_i (exp_rel),
		.err_cnt_o (chk_errs)
	);

	initial begin
		clk_4x_w = 1'b0;
		forever #50 clk_4x_w = !clk_4x_w;
	end

	// External slave model, acks one cycle after its strobe with its slave index
	always @(posedge clk_4x_w) begin
		for (int k = 0; k < EXT; k++) begin
			pend[k] = s_cyc[k] && s_stb[k] && !s_rsp[k].ack;
		end
	end

	always @(negedge clk_4x_w) begin
		for (int k = 0; k < EXT; k++) begin
			s_rsp[k].bsy = 1'b0;
			s_rsp[k].ack = pend[k];
			s_rsp[k].dat = (k == 0) ? 32'd0 : 32'(k + 1);
		end
	end

	task automatic bus_access(input logic [31:0] addr, input logic we, input logic [31:0] wdat,
			input logic [31:0] exp_d, input logic [EXT-1:0] exp_s);
		int n;
		@(negedge clk_4x_w);
		m_req.cyc = 1'b1;
		m_req.stb = 1'b1;
		m_req.we  = we;
		m_req.addr = addr[31:2];
		m_req.sel = 4'hf;
		m_req.dat = wdat;
		exp_dat = exp_d;
		exp_stb = exp_s;
		chk_dat = !we;
		n = 0;
		do begin
			@(posedge clk_4x_w);
			n++;
		end while (!m_rsp.ack && n < 20);
		if (!m_rsp.ack) begin
			$display("Bus access to %h was not acknowledged within 20 cycles", addr);
			bus_errs++;
		end
		@(negedge clk_4x_w);
		m_req   = '0;
		chk_dat = 1'b0;
		exp_stb = '0;
	endtask

	// Address outside every window, held for 20 cycles
	task automatic invalid_access(input logic [31:0] addr);
		@(negedge clk_4x_w);
		m_req.cyc  = 1'b1;
		m_req.stb  = 1'b1;
		m_req.addr = addr[31:2];
		m_req.sel  = 4'hf;
		exp_stb = '0;
		noack   = 1'b1;
		repeat (20) @(posedge clk_4x_w);
		@(negedge clk_4x_w);
		m_req = '0;
		noack = 1'b0;
	endtask

	// Called on a falling edge right at the event that starts the countdown
	task automatic mark_and_wait(input logic [31:0] cycles);
		int n;
		mark    = 1'b1;
		exp_rel = cycles;
		@(negedge clk_4x_w);
		mark = 1'b0;
		n = 0;
		do begin
			@(posedge clk_4x_w);
			n++;
		end while (sys_rst && n < 60);
		if (sys_rst) begin
			$display("sys_rst_o stayed high for 60 cycles");
			bus_errs++;
		end
		@(negedge clk_4x_w);
	endtask

	initial begin
		logic [31:0] op;
		logic [31:0] addr;
		logic [31:0] wdat;
		logic [31:0] expv;
		logic [31:0] mask;
		devtbl_rst2_w = 1'b1;
		usr_btn_n_i   = 1'b1;
		pll_locked_i  = 1'b1;
		cpu_rst_i     = 1'b0;
		m_req   = '0;
		exp_dat = '0;
		exp_stb = '0;
		chk_dat = 1'b0;
		noack   = 1'b0;
		mark    = 1'b0;
		hold    = 1'b0;
		exp_rel = '0;
		bus_errs = 0;
		for (int k = 0; k < EXT; k++) begin
			s_rsp[k] = '0;
		end
		for (int i = 0; i < NFIELD * MAXREC; i++) begin
			stim_mem[i] = '0;
		end
		$readmemh("soc_stim.txt", stim_mem);
		nrec = 0;
		while (nrec < MAXREC && stim_mem[nrec * NFIELD] != 0) begin
			nrec++;
		end
		for (int r = 0; r < nrec; r++) begin
			op   = stim_mem[r * NFIELD];
			addr = stim_mem[r * NFIELD + 1];
			wdat = stim_mem[r * NFIELD + 2];
			expv = stim_mem[r * NFIELD + 3];
			mask = stim_mem[r * NFIELD + 4];
			case (op)
				1: bus_access(addr, 1'b0, 32'h0, expv, mask[EXT-1:0]);
				2: bus_access(addr, 1'b1, wdat, 32'h0, mask[EXT-1:0]);
				3: invalid_access(addr);
				4: begin
					bus_access(addr, 1'b1, wdat, 32'h0, mask[EXT-1:0]);
					mark_and_wait(expv);
				end
				5: begin
					bus_access(addr, 1'b1, wdat, 32'h0, mask[EXT-1:0]);
					hold = 1'b1;
					repeat (30) @(negedge clk_4x_w);
					hold = 1'b0;
					usr_btn_n_i = 1'b0;
					repeat (3) @(negedge clk_4x_w);
					usr_btn_n_i = 1'b1;
					mark_and_wait(expv);
				end
				6: begin
					devtbl_rst2_w = 1'b1;
					repeat (3) @(negedge clk_4x_w);
					devtbl_rst2_w = 1'b0;
					mark_and_wait(expv);
				end
				default: begin
					$display("Unknown operation %0d in record %0d", op, r);
					bus_errs++;
				end
			endcase
		end
		repeat (5) @(negedge clk_4x_w);
		$display("Summary: %0d records, %0d checker errors, %0d other errors",
			nrec, chk_errs, bus_errs);
		if (chk_errs == 0 && bus_errs == 0 && nrec > 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	// Watchdog sized from the record count
	initial begin
		wait (nrec > 0);
		repeat (nrec * 40 + 3 + 20) @(posedge clk_4x_w);
		$display("Timeout: the run did not finish in time");
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- soc_stim.txt
// op addr wdata expected stbmask; op 1 read, 2 write, 3 unmapped, 4 warm, 5 power-off, 6 reset
// For 4, 5 and 6 expected is the cycle count until sys_rst_o falls
6 00000000 00000000 0000000f 00
1 00001000 00000000 80000004 00
1 00001004 00000000 00001000 00
1 00001008 00000000 00000007 00
1 00001018 00000000 80000005 00
1 00001020 00000000 00000001 00
1 00001024 00000000 20000000 00
1 0000102c 00000000 00010000 00
1 00001040 00000000 00000000 00
1 00001100 00000000 00000000 00
1 00000010 00000000 00000000 01
1 00002000 00000000 00000002 02
1 00003ffc 00000000 00000003 04
1 00004000 00000000 00000004 08
1 20003ffc 00000000 00000004 08
1 20004000 00000000 00000005 10
1 20014ff0 00000000 00000006 20
3 20015000 00000000 00000000 00
3 fffffffc 00000000 00000000 00
// Warm: one cycle to rise, one to reload, then 15
4 00001040 00000002 00000010 00
1 00001040 00000000 00000000 00
5 00001040 00000001 0000000f 00
1 00001000 00000000 80000004 00

//--- build.f
sysctl_pkg.sv
devmap_pkg.sv
rst_seq.sv
pi_decoder.sv
devtbl_regs.sv
soc_sysctl_top.sv
tb_checker.sv
tb_soc_sysctl.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_soc_sysctl \
	-f build.f -Mdir obj_dir -o sim > compile.log 2>&1
if [ $? -ne 0 ]; then
	cat compile.log
	echo "Compilation failed"
	exit 1
fi

./obj_dir/sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "\*\*\* TEST PASSED \*\*\*" sim.log; then
	exit 0
fi
exit 1
